// ==== build.f ====
bus_pkg.sv
core_pkg.sv
request_arbiter.sv
mem_port.sv
instruction_hold.sv
request_unit_top.sv
tb_mem_model.sv
tb_request_unit.sv

// ==== tb_request_unit.sv ====
`timescale 1ns/1ps

module tb_request_unit;

    localparam int WAIT_LIMIT = 100;

    logic                          clk;
    logic                          rst;
    logic [bus_pkg::ADDR_W-1:0]    pc;
    logic                          branch_taken;
    logic [bus_pkg::ADDR_W-1:0]    branch_target;
    logic                          mem_read;
    logic                          mem_write;
    logic [bus_pkg::ADDR_W-1:0]    mem_addr;
    logic [bus_pkg::DATA_W-1:0]    mem_wdata;
    logic [core_pkg::INSTR_W-1:0]  instr;
    logic [bus_pkg::DATA_W-1:0]    load_data;
    logic                          fetch_fault;
    logic                          freeze;
    logic                          req_valid;
    logic [bus_pkg::ADDR_W-1:0]    req_addr;
    logic                          req_write;
    logic [bus_pkg::DATA_W-1:0]    req_wdata;
    logic                          req_ready;
    logic                          resp_valid;
    logic [bus_pkg::DATA_W-1:0]    resp_data;
    logic                          resp_error;

    logic [bus_pkg::DATA_W-1:0]    ref_words [0:1023];
    string                         test_name;
    logic [core_pkg::INSTR_W-1:0]  exp_instr;
    logic                          exp_fault;
    logic [bus_pkg::DATA_W-1:0]    exp_load;
    logic                          check_load;
    logic [bus_pkg::ADDR_W-1:0]    exp_addr;
    logic                          exp_write;
    logic [bus_pkg::DATA_W-1:0]    exp_wdata;
    int                            error_count;
    int                            errors_before;
    int                            test_count;
    bit                            timed_out;

    request_unit_top #(.reset_pc(32'h100)) u_dut (.*);

    tb_mem_model u_mem (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    a_reset_state: assert property (@(posedge clk)
        rst ##1 rst |-> freeze && !req_valid && !fetch_fault && load_data == '0
            && instr == core_pkg::NOP_INSTR)
    else begin
        error_count++;
        $display("FAILED reset_state: freeze/valid/fault/load/instr expected %s actual %s",
                 $sformatf("1/0/0/00000000/%h", core_pkg::NOP_INSTR),
                 $sformatf("%b/%b/%b/%h/%h", $sampled(freeze), $sampled(req_valid),
                           $sampled(fetch_fault), $sampled(load_data), $sampled(instr)));
    end

    a_release_instr: assert property (@(posedge clk) disable iff (rst)
        !freeze |-> instr == exp_instr && fetch_fault == exp_fault)
    else begin
        error_count++;
        $display("FAILED %s: instr/fetch_fault expected %h/%b actual %h/%b", test_name,
                 exp_instr, exp_fault, $sampled(instr), $sampled(fetch_fault));
    end

    a_release_load: assert property (@(posedge clk) disable iff (rst)
        !freeze && check_load |-> load_data == exp_load)
    else begin
        error_count++;
        $display("FAILED %s: load_data expected %h actual %h", test_name, exp_load,
                 $sampled(load_data));
    end

    // Also checks that the data request comes before the fetch
    a_request: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |-> req_addr == exp_addr && req_write == exp_write
            && (!exp_write || req_wdata == exp_wdata))
    else begin
        error_count++;
        $display("FAILED %s: addr/write/wdata expected %h/%b/%h actual %h/%b/%h", test_name,
                 exp_addr, exp_write, exp_wdata, $sampled(req_addr), $sampled(req_write),
                 $sampled(req_wdata));
    end

    a_request_held: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_addr) && $stable(req_write)
            && $stable(req_wdata))
    else begin
        error_count++;
        $display("FAILED %s: held request addr expected %h actual %h", test_name,
                 $past(req_addr), $sampled(req_addr));
    end

    a_release_once: assert property (@(posedge clk) disable iff (rst)
        !freeze |-> $past(resp_valid) && $past(freeze))
    else begin
        error_count++;
        $display("Test %s: freeze dropped without a fresh fetch response", test_name);
    end

    function automatic logic [bus_pkg::DATA_W-1:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h6C3A_0000;
    endfunction

    // Waits for an accepted request or for the release cycle, ending 1 ns past the edge
    task automatic wait_for(input bit accept, input string what);
        int n;
        bit hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && !timed_out) begin
            @(posedge clk);
            hit = accept && req_valid && req_ready;
            #1;
            hit = hit || (!accept && !freeze);
            n++;
            if (!hit && n >= WAIT_LIMIT) begin
                $display("Timeout: %s never came in test %s", what, test_name);
                error_count++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic report_test();
        test_count++;
        $display("Test %s finished with %0d errors", test_name, error_count - errors_before);
        errors_before = error_count;
    endtask

    task automatic start_step(input logic rd, input logic wr,
                              input logic [bus_pkg::ADDR_W-1:0] addr,
                              input logic [bus_pkg::DATA_W-1:0] wdata,
                              input logic [bus_pkg::ADDR_W-1:0] fetch_addr);
        if (wr) begin
            ref_words[addr[11:2]] = wdata;
        end
        exp_load   = ref_words[addr[11:2]];
        check_load = rd;
        exp_fault  = (fetch_addr >= 32'hF00) && (fetch_addr <= 32'hFFF);
        exp_instr  = exp_fault ? core_pkg::NOP_INSTR : ref_words[fetch_addr[11:2]];
        if (rd || wr) begin
            exp_addr  = addr;
            exp_write = wr;
            exp_wdata = wdata;
            wait_for(1'b1, "the data request");
        end
        exp_addr  = fetch_addr;
        exp_write = 1'b0;
        wait_for(1'b1, "the fetch request");
        wait_for(1'b0, "the release cycle");
    endtask

    // Entered in a release cycle, the only cycle where the core may change its outputs
    task automatic run_step(input string name,
                            input logic [bus_pkg::ADDR_W-1:0] next_pc,
                            input logic br,
                            input logic [bus_pkg::ADDR_W-1:0] target,
                            input logic rd,
                            input logic wr,
                            input logic [bus_pkg::ADDR_W-1:0] addr,
                            input logic [bus_pkg::DATA_W-1:0] wdata);
        if (timed_out) begin
            return;
        end
        pc            = next_pc;
        branch_taken  = br;
        branch_target = target;
        mem_read      = rd;
        mem_write     = wr;
        mem_addr      = addr;
        mem_wdata     = wdata;
        @(posedge clk);
        #1;
        report_test();
        test_name = name;
        start_step(rd, wr, addr, wdata, br ? target : next_pc);
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) begin
            ref_words[i] = fill_word(i * 4);
        end
        rst           = 1'b1;
        pc            = 32'h100;
        branch_taken  = 1'b0;
        branch_target = '0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        mem_addr      = '0;
        mem_wdata     = '0;
        check_load    = 1'b0;
        exp_instr     = core_pkg::NOP_INSTR;
        exp_fault     = 1'b0;
        exp_load      = '0;
        exp_addr      = 32'h100;
        exp_write     = 1'b0;
        exp_wdata     = '0;
        error_count   = 0;
        errors_before = 0;
        test_count    = 0;
        timed_out     = 1'b0;
        test_name     = "reset_fetch";
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        start_step(1'b0, 1'b0, '0, '0, 32'h100);
        run_step("sequential_fetch", 32'h104, 0, '0, 0, 0, '0, '0);
        run_step("store_word", 32'h108, 0, '0, 0, 1, 32'h200, 32'hCAFE_0001);
        run_step("load_back", 32'h10C, 0, '0, 1, 0, 32'h200, '0);
        run_step("taken_branch", 32'h110, 1, 32'h300, 0, 0, '0, '0);
        run_step("after_branch", 32'h304, 0, '0, 0, 0, '0, '0);
        run_step("store_over_next_fetch", 32'h308, 0, '0, 0, 1, 32'h308, 32'h1234_5678);
        run_step("fetch_error_window", 32'h30C, 1, 32'hF40, 0, 0, '0, '0);
        run_step("branch_out_of_fault", 32'hF44, 1, 32'h120, 1, 0, 32'h308, '0);
        for (int i = 0; i < 8; i++) begin
            run_step((i % 2 == 0) ? "store_run" : "load_run", 32'h124 + 4 * i, 0, '0,
                     (i % 2 == 1), (i % 2 == 0), 32'h400 + (i / 2) * 4, 32'hA5A5_0000 + i);
        end
        @(posedge clk);
        #1;
        report_test();
        $display("Summary: %0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    input  logic [bus_pkg::ADDR_W-1:0]  req_addr,
    input  logic                        req_write,
    input  logic [bus_pkg::DATA_W-1:0]  req_wdata,
    output logic                        req_ready,
    output logic                        resp_valid,
    output logic [bus_pkg::DATA_W-1:0]  resp_data,
    output logic                        resp_error
);

    logic [bus_pkg::DATA_W-1:0] words [0:1023];
    logic [bus_pkg::ADDR_W-1:0] addr_q;
    logic                       write_q;
    logic                       accepted;
    logic                       pending;
    int unsigned                delay;

    function automatic logic [bus_pkg::DATA_W-1:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h6C3A_0000;
    endfunction

    function automatic logic in_error_window(input logic [bus_pkg::ADDR_W-1:0] a);
        return (a >= 32'hF00) && (a <= 32'hFFF);
    endfunction

    // A single process draws every random number, so the seed fixes the whole run
    initial begin
        delay = $urandom(32'hd6d3);
        for (int i = 0; i < 1024; i++) begin
            words[i] = fill_word(i * 4);
        end
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        resp_data  = '0;
        resp_error = 1'b0;
        pending    = 1'b0;
        forever begin
            @(posedge clk);
            accepted = req_valid && req_ready;
            if (accepted) begin
                addr_q  = req_addr;
                write_q = req_write;
                if (req_write && !in_error_window(req_addr)) begin
                    words[req_addr[11:2]] = req_wdata;
                end
            end
            #1;
            resp_valid = 1'b0;
            if (accepted) begin
                pending = 1'b1;
                delay   = $urandom % 4;
            end
            // Response lands 1 to 4 cycles after acceptance
            if (pending && delay == 0) begin
                resp_valid = 1'b1;
                resp_error = in_error_window(addr_q);
                resp_data  = (write_q || resp_error) ? 32'hDEAD_BEEF : words[addr_q[11:2]];
                pending    = 1'b0;
            end else if (pending) begin
                delay = delay - 1;
            end
            req_ready = !rst && ($urandom % 3 != 0);
        end
    end

endmodule

// ==== request_unit_top.sv ====
`timescale 1ns/1ps

module request_unit_top #(
    parameter logic [bus_pkg::ADDR_W-1:0] reset_pc = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    // Core side
    input  logic [bus_pkg::ADDR_W-1:0]    pc,
    input  logic                          branch_taken,
    input  logic [bus_pkg::ADDR_W-1:0]    branch_target,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic [bus_pkg::ADDR_W-1:0]    mem_addr,
    input  logic [bus_pkg::DATA_W-1:0]    mem_wdata,
    output logic [core_pkg::INSTR_W-1:0]  instr,
    output logic [bus_pkg::DATA_W-1:0]    load_data,
    output logic                          fetch_fault,
    output logic                          freeze,
    // Memory side
    output logic                          req_valid,
    output logic [bus_pkg::ADDR_W-1:0]    req_addr,
    output logic                          req_write,
    output logic [bus_pkg::DATA_W-1:0]    req_wdata,
    input  logic                          req_ready,
    input  logic                          resp_valid,
    input  logic [bus_pkg::DATA_W-1:0]    resp_data,
    input  logic                          resp_error
);

    logic                       issue;
    bus_pkg::access_t           issue_kind;
    logic [bus_pkg::ADDR_W-1:0] issue_addr;
    logic [bus_pkg::DATA_W-1:0] issue_wdata;
    logic                       done;
    bus_pkg::access_t           done_kind;
    logic [bus_pkg::DATA_W-1:0] done_data;
    logic                       done_error;
    logic                       capture;
    logic                       fault_capture;
    logic                       flush;

    request_arbiter #(
        .reset_pc (reset_pc)
    ) u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .done          (done),
        .done_kind     (done_kind),
        .done_error    (done_error),
        .issue         (issue),
        .issue_kind    (issue_kind),
        .issue_addr    (issue_addr),
        .issue_wdata   (issue_wdata),
        .capture       (capture),
        .fault_capture (fault_capture),
        .flush         (flush),
        .freeze        (freeze)
    );

    mem_port u_mem_port (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .issue_kind  (issue_kind),
        .issue_addr  (issue_addr),
        .issue_wdata (issue_wdata),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_error  (resp_error),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_write   (req_write),
        .req_wdata   (req_wdata),
        .done        (done),
        .done_kind   (done_kind),
        .done_data   (done_data),
        .done_error  (done_error),
        .load_data   (load_data)
    );

    instruction_hold u_hold (
        .clk           (clk),
        .rst           (rst),
        .capture       (capture),
        .fault_capture (fault_capture),
        .flush         (flush),
        .done_data     (done_data),
        .instr         (instr),
        .fetch_fault   (fetch_fault)
    );

endmodule

// ==== instruction_hold.sv ====
`timescale 1ns/1ps

module instruction_hold (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          capture,
    input  logic                          fault_capture,
    input  logic                          flush,
    input  logic [bus_pkg::DATA_W-1:0]    done_data,
    output logic [core_pkg::INSTR_W-1:0]  instr,
    output logic                          fetch_fault
);

    // Word stays put through the whole freeze
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr       <= core_pkg::NOP_INSTR;
            fetch_fault <= 1'b0;
        end else if (capture) begin
            instr       <= done_data;
            fetch_fault <= 1'b0;
        end else if (fault_capture) begin
            // Bad fetch shows up as a no-op with the flag raised
            instr       <= core_pkg::NOP_INSTR;
            fetch_fault <= 1'b1;
        end else if (flush) begin
            instr       <= core_pkg::NOP_INSTR;
            fetch_fault <= 1'b0;
        end
    end

    a_capture_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(capture && fault_capture)
    );

endmodule

// ==== mem_port.sv ====
`timescale 1ns/1ps

module mem_port (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue,
    input  bus_pkg::access_t            issue_kind,
    input  logic [bus_pkg::ADDR_W-1:0]  issue_addr,
    input  logic [bus_pkg::DATA_W-1:0]  issue_wdata,
    input  logic                        req_ready,
    input  logic                        resp_valid,
    input  logic [bus_pkg::DATA_W-1:0]  resp_data,
    input  logic                        resp_error,
    output logic                        req_valid,
    output logic [bus_pkg::ADDR_W-1:0]  req_addr,
    output logic                        req_write,
    output logic [bus_pkg::DATA_W-1:0]  req_wdata,
    output logic                        done,
    output bus_pkg::access_t            done_kind,
    output logic [bus_pkg::DATA_W-1:0]  done_data,
    output logic                        done_error,
    output logic [bus_pkg::DATA_W-1:0]  load_data
);

    logic             outstanding;
    bus_pkg::access_t kind_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_valid   <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            if (issue) begin
                req_valid <= 1'b1;
            end else if (req_valid && req_ready) begin
                req_valid   <= 1'b0;
                outstanding <= 1'b1;
            end
            if (resp_valid) begin
                outstanding <= 1'b0;
            end
        end
    end

    // Request fields and kind are captured once per issue
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr  <= issue_addr;
            req_write <= (issue_kind == bus_pkg::ACC_STORE);
            req_wdata <= issue_wdata;
            kind_q    <= issue_kind;
        end
    end

    assign done       = resp_valid;
    assign done_kind  = kind_q;
    assign done_data  = resp_data;
    assign done_error = resp_error;

    // Only load completions touch the word returned to the core
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_data <= '0;
        end else if (resp_valid && kind_q == bus_pkg::ACC_LOAD) begin
            load_data <= resp_data;
        end
    end

    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        req_valid && !req_ready |=>
            req_valid && $stable(req_addr) && $stable(req_write) && $stable(req_wdata)
    );

    a_no_overlap: assert property (
        @(posedge clk) disable iff (rst)
        issue |-> !outstanding && !req_valid
    );

    a_resp_expected: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid |-> outstanding
    );

endmodule

// ==== request_arbiter.sv ====
`timescale 1ns/1ps

module request_arbiter #(
    parameter logic [bus_pkg::ADDR_W-1:0] reset_pc = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [bus_pkg::ADDR_W-1:0]  pc,
    input  logic                        branch_taken,
    input  logic [bus_pkg::ADDR_W-1:0]  branch_target,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  logic [bus_pkg::ADDR_W-1:0]  mem_addr,
    input  logic [bus_pkg::DATA_W-1:0]  mem_wdata,
    input  logic                        done,
    input  bus_pkg::access_t            done_kind,
    input  logic                        done_error,
    output logic                        issue,
    output bus_pkg::access_t            issue_kind,
    output logic [bus_pkg::ADDR_W-1:0]  issue_addr,
    output logic [bus_pkg::DATA_W-1:0]  issue_wdata,
    output logic                        capture,
    output logic                        fault_capture,
    output logic                        flush,
    output logic                        freeze
);

    bus_pkg::step_state_t state;
    bus_pkg::step_state_t state_next;

    logic                       entered;
    logic                       redirect;
    logic [bus_pkg::ADDR_W-1:0] target_q;
    logic                       data_req;
    logic                       fetch_done;
    logic [bus_pkg::ADDR_W-1:0] fetch_addr;

    assign data_req   = mem_read || mem_write;
    assign fetch_done = done && (done_kind == bus_pkg::ACC_FETCH);

    // Redirect is preset out of reset so the first fetch goes to reset_pc
    assign fetch_addr = redirect ? target_q : pc;

    always_comb begin
        state_next = state;
        case (state)
            bus_pkg::ST_IDLE: begin
                state_next = data_req ? bus_pkg::ST_DATA : bus_pkg::ST_FETCH;
            end
            bus_pkg::ST_DATA: begin
                if (done && done_kind != bus_pkg::ACC_FETCH) begin
                    state_next = bus_pkg::ST_FETCH;
                end
            end
            bus_pkg::ST_FETCH: begin
                if (fetch_done) begin
                    state_next = bus_pkg::ST_RELEASE;
                end
            end
            default: begin
                state_next = bus_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= bus_pkg::ST_IDLE;
            entered  <= 1'b0;
            issue    <= 1'b0;
            flush    <= 1'b0;
            redirect <= 1'b1;
            target_q <= reset_pc;
        end else begin
            state   <= state_next;
            entered <= (state_next != state) &&
                       (state_next == bus_pkg::ST_DATA || state_next == bus_pkg::ST_FETCH);
            // Issue trails state entry by one cycle
            issue   <= entered;
            flush   <= (state == bus_pkg::ST_RELEASE) && branch_taken;
            if (state == bus_pkg::ST_RELEASE) begin
                redirect <= branch_taken;
                target_q <= branch_target;
            end
        end
    end

    // Core inputs are held while frozen, so the request fields can be combinational
    always_comb begin
        if (state == bus_pkg::ST_DATA) begin
            issue_kind = mem_write ? bus_pkg::ACC_STORE : bus_pkg::ACC_LOAD;
            issue_addr = mem_addr;
        end else begin
            issue_kind = bus_pkg::ACC_FETCH;
            issue_addr = fetch_addr;
        end
    end

    assign issue_wdata = mem_wdata;

    assign capture       = fetch_done && !done_error;
    assign fault_capture = fetch_done && done_error;

    assign freeze = (state != bus_pkg::ST_RELEASE);

    // One release cycle per step
    a_single_release: assert property (
        @(posedge clk) disable iff (rst)
        !freeze |=> freeze
    );

endmodule

// ==== core_pkg.sv ====
package core_pkg;

    // Instruction word as seen by the core
    localparam int INSTR_W = 32;

    // addi x0, x0, 0
    // Shown after reset, after a flush and in place of a faulted fetch
    localparam logic [INSTR_W-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

    // Memory bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Kind of access carried by one request on the single memory port
    typedef enum logic [1:0] {
        ACC_FETCH = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_t;

    // Step sequencer states
    // ST_DATA and ST_FETCH are the two wait states with a transfer in flight
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_DATA    = 2'd1,
        ST_FETCH   = 2'd2,
        ST_RELEASE = 2'd3
    } step_state_t;

endpackage
